//--- Bender.yml
package:
  name: i2s_dac_out

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/audio_types_pkg.sv
      - logic/i2s_bus_pkg.sv
      - logic/sample_saturator.sv
      - logic/i2s_edge_sync.sv
      - logic/i2s_serializer.sv
      - logic/i2s_dac_out.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/i2s_dac_out_tb.sv

//--- logic/audio_settings.svh
//--------------------------------------------------------------------------
// Audio output stage settings
// Sample widths, synchronizer depth and I2S slot counter size shared by
// the packages and the RTL of the DAC output path
//--------------------------------------------------------------------------

`ifndef AUDIO_SETTINGS_SVH
`define AUDIO_SETTINGS_SVH

//--------------------------------------------------------------------------
// Sample widths
//--------------------------------------------------------------------------

// One incoming channel sample from the processing chain
`define AUDIO_IN_WIDTH 18

// One channel word on the link
// Saturation rule expects this to be one bit narrower than the input
`define AUDIO_OUT_WIDTH 17

//--------------------------------------------------------------------------
// Link side
//--------------------------------------------------------------------------

// Flops in each link clock synchronizer chain
`define I2S_SYNC_STAGES 2

// Bit counter inside one channel slot, covers slots up to 63 bits
`define I2S_SLOT_CNT_WIDTH 6

`endif

//--- logic/audio_types_pkg.sv
//--------------------------------------------------------------------------
// Audio sample types
// Wide samples from the processing chain and narrow saturated samples
// that go out on the DAC link
//--------------------------------------------------------------------------

`default_nettype none

`include "audio_settings.svh"

package audio_types_pkg;

    //----------------------------------------------------------------------
    // Sample formats
    //----------------------------------------------------------------------

    // Two's complement sample as produced upstream
    typedef logic signed [`AUDIO_IN_WIDTH-1:0] sample_in_t;

    // Saturated sample, one channel word on the link
    // Range is 17'h10000 up to 17'h0FFFF
    typedef logic signed [`AUDIO_OUT_WIDTH-1:0] sample_out_t;

endpackage : audio_types_pkg

`default_nettype wire

//--- logic/i2s_bus_pkg.sv
//--------------------------------------------------------------------------
// I2S link types
// Channel select encoding of the word clock and the slot bit counter
//--------------------------------------------------------------------------

`default_nettype none

`include "audio_settings.svh"

package i2s_bus_pkg;

    // Word clock level selects the channel
    // Low is left, high is right, as in standard I2S
    typedef enum logic {
        I2S_LEFT  = 1'b0,
        I2S_RIGHT = 1'b1
    } i2s_channel_e;

    // Counts bits already sent in the current channel slot
    typedef logic [`I2S_SLOT_CNT_WIDTH-1:0] slot_cnt_t;

endpackage : i2s_bus_pkg

`default_nettype wire

//--- logic/i2s_dac_out.sv
//--------------------------------------------------------------------------
// I2S DAC output stage
// Saturates stereo samples to the link width and sends them to an
// external DAC over I2S, with the codec as link clock master
//--------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "audio_settings.svh"

module i2s_dac_out (
    // System clock on reset, asynchronous reset on clk
    input  logic                        reset,
    input  logic                        clk,
    // Samples from the processing chain
    input  logic                        sample_in_rdy,
    input  audio_types_pkg::sample_in_t sample_in_l,
    input  audio_types_pkg::sample_in_t sample_in_r,
    // Pulses when a pair is taken for a new frame
    output logic                        data_sampled,
    // I2S link
    input  logic                        bclk,
    input  logic                        lrclk,
    output logic                        dacda
);

    import audio_types_pkg::*;
    import i2s_bus_pkg::*;

    // Held pair between saturator and serializer
    sample_out_t  sat_l;
    sample_out_t  sat_r;
    // Synchronized link timing
    logic         bclk_fall;
    i2s_channel_e lrclk_sync;

    // Input side
    sample_saturator u_sample_saturator (
        .reset         (reset),
        .clk           (clk),
        .sample_in_rdy (sample_in_rdy),
        .sample_in_l   (sample_in_l),
        .sample_in_r   (sample_in_r),
        .sat_l         (sat_l),
        .sat_r         (sat_r)
    );

    // Link clocks into the system domain, rising edges not needed here
    i2s_edge_sync u_i2s_edge_sync (
        .reset      (reset),
        .clk        (clk),
        .bclk       (bclk),
        .lrclk      (lrclk),
        .bclk_rise  (),
        .bclk_fall  (bclk_fall),
        .lrclk_sync (lrclk_sync)
    );

    // Output side
    i2s_serializer u_i2s_serializer (
        .reset        (reset),
        .clk          (clk),
        .sat_l        (sat_l),
        .sat_r        (sat_r),
        .bclk_fall    (bclk_fall),
        .lrclk_sync   (lrclk_sync),
        .data_sampled (data_sampled),
        .dacda        (dacda)
    );

endmodule : i2s_dac_out

`default_nettype wire

//--- logic/i2s_edge_sync.sv
//--------------------------------------------------------------------------
// I2S link clock synchronizer
// Brings the codec bit clock and word clock into the system clock domain
// and marks the bit clock edges with one-cycle pulses
//--------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "audio_settings.svh"

module i2s_edge_sync (
    // System clock on reset, asynchronous reset on clk
    input  logic                      reset,
    input  logic                      clk,
    // Link clocks from the codec, asynchronous
    input  logic                      bclk,
    input  logic                      lrclk,
    // Edge pulses and synchronized channel select
    output logic                      bclk_rise,
    output logic                      bclk_fall,
    output i2s_bus_pkg::i2s_channel_e lrclk_sync
);

    import i2s_bus_pkg::*;

    // Synchronizer chains, bit 0 samples the pin
    logic [`I2S_SYNC_STAGES-1:0] bclk_sync_q;
    logic [`I2S_SYNC_STAGES-1:0] lrclk_sync_q;
    // Last bit clock stage delayed once more for edge detection
    logic                        bclk_dly_q;

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            bclk_sync_q  <= '0;
            lrclk_sync_q <= '0;
            bclk_dly_q   <= 1'b0;
        end else begin
            // Equal depth keeps lrclk aligned with its launching bclk edge
            bclk_sync_q  <= {bclk_sync_q[`I2S_SYNC_STAGES-2:0], bclk};
            lrclk_sync_q <= {lrclk_sync_q[`I2S_SYNC_STAGES-2:0], lrclk};
            bclk_dly_q   <= bclk_sync_q[`I2S_SYNC_STAGES-1];
        end
    end

    //----------------------------------------------------------------------
    // Edge pulses
    //----------------------------------------------------------------------

    // New level high, old level low
    assign bclk_rise  = bclk_sync_q[`I2S_SYNC_STAGES-1] & ~bclk_dly_q;
    // New level low, old level high
    assign bclk_fall  = ~bclk_sync_q[`I2S_SYNC_STAGES-1] & bclk_dly_q;

    // Word clock level, already valid in the bclk_fall cycle that follows
    assign lrclk_sync = i2s_channel_e'(lrclk_sync_q[`I2S_SYNC_STAGES-1]);

endmodule : i2s_edge_sync

`default_nettype wire

//--- logic/i2s_serializer.sv
//--------------------------------------------------------------------------
// I2S serializer
// Latches the held pair at each left frame start and shifts each channel
// word out MSB first on the bit clock falling edges, zero padded per slot
//--------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "audio_settings.svh"

module i2s_serializer (
    // System clock on reset, asynchronous reset on clk
    input  logic                         reset,
    input  logic                         clk,
    // Held pair from the saturator
    input  audio_types_pkg::sample_out_t sat_l,
    input  audio_types_pkg::sample_out_t sat_r,
    // Synchronized link timing
    input  logic                         bclk_fall,
    input  i2s_bus_pkg::i2s_channel_e    lrclk_sync,
    // Frame start marker and serial data to the DAC
    output logic                         data_sampled,
    output logic                         dacda
);

    import audio_types_pkg::*;
    import i2s_bus_pkg::*;

    // Bits of real data at the start of each slot
    localparam slot_cnt_t word_bits = slot_cnt_t'(`AUDIO_OUT_WIDTH);

    i2s_channel_e lr_prev_q;
    sample_out_t  frame_l_q;
    sample_out_t  frame_r_q;
    sample_out_t  shift_q;
    slot_cnt_t    slot_cnt_q;
    logic         load_q;
    logic         lr_change;
    logic         frame_start;
    logic         next_bit;

    //----------------------------------------------------------------------
    // Slot boundaries
    //----------------------------------------------------------------------

    // Word clock level differs from the one seen at the previous fall
    assign lr_change   = bclk_fall && (lrclk_sync != lr_prev_q);
    // Right to left change opens a new frame
    assign frame_start = lr_change && (lrclk_sync == I2S_LEFT);

    // Data bit while inside the word, zero padding after it
    assign next_bit = (slot_cnt_q < word_bits) ? shift_q[`AUDIO_OUT_WIDTH-1] : 1'b0;

    //----------------------------------------------------------------------
    // Frame registers
    //----------------------------------------------------------------------

    // Both channels taken together so a frame never mixes two pairs
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            frame_l_q    <= '0;
            frame_r_q    <= '0;
            data_sampled <= 1'b0;
        end else begin
            data_sampled <= frame_start;
            if (frame_start) begin
                frame_l_q <= sat_l;
                frame_r_q <= sat_r;
            end
        end
    end

    //----------------------------------------------------------------------
    // Shift register and slot counter
    //----------------------------------------------------------------------

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            lr_prev_q  <= I2S_LEFT;
            load_q     <= 1'b0;
            shift_q    <= '0;
            slot_cnt_q <= '0;
            dacda      <= 1'b0;
        end else begin
            // Load one cycle after the change, frame registers are settled
            load_q <= lr_change;
            if (load_q) begin
                // lr_prev_q already holds the new channel here
                shift_q <= (lr_prev_q == I2S_LEFT) ? frame_l_q : frame_r_q;
            end else if (bclk_fall) begin
                shift_q <= shift_q << 1;
            end

            if (bclk_fall) begin
                lr_prev_q <= lrclk_sync;
                // Change edge still sends the last bit of the old slot
                dacda     <= next_bit;
                if (lr_change) begin
                    slot_cnt_q <= '0;
                end else if (slot_cnt_q != word_bits) begin
                    // Stops at the word length, rest of slot is padding
                    slot_cnt_q <= slot_cnt_q + 1'b1;
                end
            end
        end
    end

endmodule : i2s_serializer

`default_nettype wire

//--- logic/sample_saturator.sv
//--------------------------------------------------------------------------
// Sample saturator
// Captures a stereo pair on the ready strobe and narrows each channel to
// the link width, clipping out-of-range values instead of wrapping
//--------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "audio_settings.svh"

module sample_saturator (
    // System clock on reset, asynchronous reset on clk
    input  logic                         reset,
    input  logic                         clk,
    // Upstream sample interface
    input  logic                         sample_in_rdy,
    input  audio_types_pkg::sample_in_t  sample_in_l,
    input  audio_types_pkg::sample_in_t  sample_in_r,
    // Held pair towards the serializer
    output audio_types_pkg::sample_out_t sat_l,
    output audio_types_pkg::sample_out_t sat_r
);

    import audio_types_pkg::*;

    //----------------------------------------------------------------------
    // Saturation rule
    //----------------------------------------------------------------------

    // Top two bits tell whether the value fits in one bit less
    // 01 is too large, 10 is too small, 00 and 11 fit
    function automatic sample_out_t saturate(input sample_in_t din);
        logic [1:0]  top_bits;
        sample_out_t dout;
        top_bits = din[`AUDIO_IN_WIDTH-1 -: 2];
        case (top_bits)
            // Largest positive code
            2'b01:   dout = {1'b0, {(`AUDIO_OUT_WIDTH-1){1'b1}}};
            // Most negative code
            2'b10:   dout = {1'b1, {(`AUDIO_OUT_WIDTH-1){1'b0}}};
            // In range, drop the redundant sign bit
            default: dout = {din[`AUDIO_IN_WIDTH-1], din[`AUDIO_OUT_WIDTH-2:0]};
        endcase
        return dout;
    endfunction

    //----------------------------------------------------------------------
    // Held pair
    //----------------------------------------------------------------------

    // Updated only on the strobe, a later strobe overwrites the pair
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            sat_l <= '0;
            sat_r <= '0;
        end else if (sample_in_rdy) begin
            sat_l <= saturate(sample_in_l);
            sat_r <= saturate(sample_in_r);
        end
    end

endmodule : sample_saturator

`default_nettype wire

//--- sim/i2s_dac_out_tb.sv
//--------------------------------------------------------------------------
// I2S DAC output stage testbench
// Acts as the codec link master, drives sample pairs from the case file
// and decodes the serial line back into channel words
//--------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "audio_settings.svh"

module i2s_dac_out_tb;

    // Link timing, bit clock at one eighth of the 4 ns system clock
    localparam int     SLOT_BITS = 32;
    localparam int     BCLK_HALF = 16;
    localparam longint FRAME_NS  = 2 * SLOT_BITS * 2 * BCLK_HALF;
    localparam longint RESET_NS  = 10 * 4;

    // DUT ports
    logic                        reset = 1'b0;
    logic                        clk   = 1'b1;
    logic                        bclk  = 1'b1;
    logic                        lrclk = 1'b0;
    logic                        sample_in_rdy;
    logic [`AUDIO_IN_WIDTH-1:0]  sample_in_l;
    logic [`AUDIO_IN_WIDTH-1:0]  sample_in_r;
    logic                        data_sampled;
    logic                        dacda;

    // Case table from the data file
    string                       case_name[$];
    int                          case_mode[$];
    logic [`AUDIO_IN_WIDTH-1:0]  case_in_l[$];
    logic [`AUDIO_IN_WIDTH-1:0]  case_in_r[$];
    logic [`AUDIO_OUT_WIDTH-1:0] case_exp_l[$];
    logic [`AUDIO_OUT_WIDTH-1:0] case_exp_r[$];
    logic                        cases_ready = 1'b0;

    int errors    = 0;
    int checks    = 0;
    int ds_count  = 0;
    int lr_falls  = 0;
    int idle_ones = 0;

    // Decoder state
    logic                        lr_last  = 1'b0;
    int                          cur_ch   = -1;
    int                          nbits    = 0;
    int                          pad_ones = 0;
    logic [`AUDIO_OUT_WIDTH-1:0] word;
    logic                        left_done = 1'b0;
    logic [`AUDIO_OUT_WIDTH-1:0] left_word;
    int                          left_pad;
    logic [`AUDIO_OUT_WIDTH-1:0] frame_left;
    logic [`AUDIO_OUT_WIDTH-1:0] frame_right;
    int                          frame_left_pad;
    int                          frame_right_pad;
    int                          frames_done = 0;

    i2s_dac_out u_i2s_dac_out (
        .reset         (reset),
        .clk           (clk),
        .sample_in_rdy (sample_in_rdy),
        .sample_in_l   (sample_in_l),
        .sample_in_r   (sample_in_r),
        .data_sampled  (data_sampled),
        .bclk          (bclk),
        .lrclk         (lrclk),
        .dacda         (dacda)
    );

    // System clock, 4 ns period
    always #2 reset = ~reset;

    //----------------------------------------------------------------------
    // Codec side link master
    //----------------------------------------------------------------------

    // Edges sit on odd ns, away from the system clock edges
    // lrclk moves on a falling edge after every 32 bits
    initial begin
        int fall_cnt;
        fall_cnt = 0;
        #1;
        forever begin
            #(BCLK_HALF);
            bclk <= 1'b0;
            fall_cnt++;
            if (fall_cnt == SLOT_BITS) begin
                fall_cnt = 0;
                lrclk <= ~lrclk;
            end
            #(BCLK_HALF);
            bclk <= 1'b1;
        end
    end

    //----------------------------------------------------------------------
    // Serial line decoder
    //----------------------------------------------------------------------

    // Data lags lrclk by one bit, so a bit belongs to the channel seen
    // at the previous rising edge
    always @(posedge bclk) begin
        if (int'(lr_last) != cur_ch) begin
            cur_ch   = int'(lr_last);
            nbits    = 0;
            pad_ones = 0;
            word     = '0;
        end
        if (nbits < `AUDIO_OUT_WIDTH) begin
            word = {word[`AUDIO_OUT_WIDTH-2:0], dacda};
        end else if (dacda !== 1'b0) begin
            pad_ones++;
        end
        nbits++;
        // Full slot, right after left closes one frame
        if (nbits == SLOT_BITS) begin
            if (cur_ch == 0) begin
                left_word = word;
                left_pad  = pad_ones;
                left_done = 1'b1;
            end else if (left_done) begin
                frame_left      = left_word;
                frame_left_pad  = left_pad;
                frame_right     = word;
                frame_right_pad = pad_ones;
                left_done       = 1'b0;
                frames_done++;
            end
        end
        lr_last = lrclk;
    end

    // Sampled on the falling system edge where DUT outputs are stable
    always @(negedge reset) begin
        if (data_sampled === 1'b1) begin
            ds_count++;
        end
        // Line must stay quiet until the first left frame start
        if (lr_falls == 0 && dacda !== 1'b0) begin
            idle_ones++;
        end
    end

    // Each earlier frame start gave exactly one pulse
    always @(negedge lrclk) begin
        if (lr_falls == 0) begin
            check_value("reset idle dacda", 0, idle_ones);
        end
        check_value("data_sampled pulses", lr_falls, ds_count);
        lr_falls++;
    end

    //----------------------------------------------------------------------
    // Tasks
    //----------------------------------------------------------------------

    task automatic check_value(input string label, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s expected %0h actual %0h", label, expected, actual);
        end
    endtask

    task automatic load_cases();
        int    fd;
        int    rc;
        int    mode;
        string line;
        string name;
        logic [31:0] in_l;
        logic [31:0] in_r;
        logic [31:0] exp_l;
        logic [31:0] exp_r;
        fd = $fopen("sim/i2s_out_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file sim/i2s_out_cases.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                // Skip comments and empty lines
                if (line.len() > 1 && line[0] != "#") begin
                    rc = $sscanf(line, "%s %d %h %h %h %h",
                                 name, mode, in_l, in_r, exp_l, exp_r);
                    if (rc == 6) begin
                        case_name.push_back(name);
                        case_mode.push_back(mode);
                        case_in_l.push_back(in_l[`AUDIO_IN_WIDTH-1:0]);
                        case_in_r.push_back(in_r[`AUDIO_IN_WIDTH-1:0]);
                        case_exp_l.push_back(exp_l[`AUDIO_OUT_WIDTH-1:0]);
                        case_exp_r.push_back(exp_r[`AUDIO_OUT_WIDTH-1:0]);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // One strobe cycle with a new pair
    task automatic drive_pair(input logic [`AUDIO_IN_WIDTH-1:0] l,
                              input logic [`AUDIO_IN_WIDTH-1:0] r);
        @(posedge reset);
        sample_in_l   <= l;
        sample_in_r   <= r;
        sample_in_rdy <= 1'b1;
        @(posedge reset);
        sample_in_rdy <= 1'b0;
    endtask

    task automatic run_case(input int idx);
        int target;
        int err_before;
        err_before = errors;
        // Mid frame, right slot just began
        @(posedge lrclk);
        // Current frame finishes first, the next one carries the pair
        target = frames_done + 2;
        if (case_mode[idx] == 2) begin
            // Inverted pair first, overwritten before the frame start
            drive_pair(~case_in_l[idx], ~case_in_r[idx]);
            drive_pair(case_in_l[idx], case_in_r[idx]);
        end else if (case_mode[idx] == 0) begin
            drive_pair(case_in_l[idx], case_in_r[idx]);
        end
        wait (frames_done == target);
        check_value({case_name[idx], " left"}, case_exp_l[idx], frame_left);
        check_value({case_name[idx], " right"}, case_exp_r[idx], frame_right);
        check_value({case_name[idx], " left padding"}, 0, frame_left_pad);
        check_value({case_name[idx], " right padding"}, 0, frame_right_pad);
        if (errors == err_before) begin
            $display("Case %0d %s passed", idx, case_name[idx]);
        end else begin
            $display("Case %0d %s failed", idx, case_name[idx]);
        end
    endtask

    //----------------------------------------------------------------------
    // Main sequence and watchdog
    //----------------------------------------------------------------------

    initial begin
        sample_in_rdy = 1'b0;
        sample_in_l   = '0;
        sample_in_r   = '0;
        load_cases();
        if (case_name.size() == 0) begin
            $display("No test cases could be read, nothing was run");
            $display("Errors found");
            $finish;
        end else begin
            cases_ready = 1'b1;
            repeat (10) @(posedge reset);
            clk <= 1'b0;
            for (int i = 0; i < case_name.size(); i++) begin
                run_case(i);
            end
            check_value("total data_sampled pulses", lr_falls, ds_count);
            $display("Summary: %0d cases, %0d checks, %0d failed checks",
                     case_name.size(), checks, errors);
            if (errors == 0) begin
                $display("No errors");
            end else begin
                $display("Errors found");
            end
            $finish;
        end
    end

    // Three frames per case plus reset
    initial begin
        longint limit_ns;
        wait (cases_ready);
        limit_ns = case_name.size() * 3 * FRAME_NS + RESET_NS;
        #(limit_ns);
        $display("Timeout: the serial link did not deliver all frames in time");
        $display("Errors found");
        $finish;
    end

endmodule : i2s_dac_out_tb

`default_nettype wire

//--- sim/i2s_out_cases.txt
# name mode left_in right_in exp_left exp_right, values in hex
# mode 0 one strobe, 1 no strobe so the pair repeats, 2 two strobes before the frame start
reset_pair 0 00000 00000 00000 00000
small_pos 0 01234 05A5A 01234 05A5A
small_neg 0 3FFFF 3ABCD 1FFFF 1ABCD
range_ends 0 0FFFF 30000 0FFFF 10000
over_left 0 10000 00001 0FFFF 00001
over_right 0 00002 1FFFF 00002 0FFFF
under_left 0 20000 3FFFE 10000 1FFFE
under_right 0 0C0DE 2FFFF 0C0DE 10000
clip_both 0 1ABCD 25432 0FFFF 10000
hold_clip 1 00000 00000 0FFFF 10000
clip_swap 0 2AAAA 15555 10000 0FFFF
double_strobe 2 0BEEF 3CAFE 0BEEF 1CAFE
hold_double 1 00000 00000 0BEEF 1CAFE
alt_bits 0 0AAAA 35555 0AAAA 15555
near_top 0 0FFFE 10001 0FFFE 0FFFF
near_bottom 0 30001 2FFFE 10001 10000
double_clip 2 1F00F 20F0F 0FFFF 10000
half_scale 0 08000 38000 08000 18000
max_both 0 0FFFF 0FFFF 0FFFF 0FFFF
over_both 0 10000 10000 0FFFF 0FFFF
under_both 0 2FFFF 2FFFF 10000 10000
min_both 0 30000 30000 10000 10000
minus_one 0 3FFFF 3FFFF 1FFFF 1FFFF
plus_one 0 00001 00001 00001 00001
mixed_a 0 01111 32222 01111 12222
mixed_b 0 04321 3EDCB 04321 1EDCB
top_left 0 1FFFF 00100 0FFFF 00100
bottom_right 0 00200 20000 00200 10000
hold_edges 1 00000 00000 00200 10000
double_small 2 00003 3FFFD 00003 1FFFD
walk_a 0 07FFF 38001 07FFF 18001
walk_b 0 0ABCD 35432 0ABCD 15432
clip_mix_a 0 3BCDE 1BCDE 1BCDE 0FFFF
clip_mix_b 0 2BCDE 0BCDE 10000 0BCDE

//--- src.f
+incdir+logic
logic/audio_types_pkg.sv
logic/i2s_bus_pkg.sv
logic/sample_saturator.sv
logic/i2s_edge_sync.sv
logic/i2s_serializer.sv
logic/i2s_dac_out.sv
sim/i2s_dac_out_tb.sv
